// File: include/crc_defines.svh
// crc-32 link constants
// widths, generator polynomial and output shaping for the crc blocks

`ifndef CRC_DEFINES_SVH
`define CRC_DEFINES_SVH

// --------------------------------------------------
// widths
// --------------------------------------------------
`define CRC_DATA_W      8             // payload byte
`define CRC_W           32            // crc register

// --------------------------------------------------
// crc-32 settings
// --------------------------------------------------
`define CRC_POLY        32'h04C11DB7  // generator, x^32 term implied
`define CRC_PRESET      32'hFFFFFFFF  // register start value
`define CRC_XOR_OUT     32'hFFFFFFFF  // final inversion mask

// bit order modes
//   0 none, 1 full reflection
//   2 byte swap, 3 bits reversed inside each byte
`define CRC_BIT_ORDER   1

// framing
`define CRC_TAIL_BYTES  4             // crc bytes appended per frame

`endif

// File: verilog/crc_pkg.sv
// crc_pkg
// shared vector and state types for the crc-32 link

`default_nettype none

`include "crc_defines.svh"

package crc_pkg;

	typedef logic [`CRC_DATA_W-1:0] data_t; // one payload byte
	typedef logic [`CRC_W-1:0]      crc_t;  // crc register or finished value

	// transmit framer states
	typedef enum logic [1:0]
	{
		TX_IDLE, // no frame open
		TX_DATA, // payload bytes passing
		TX_TAIL  // appending crc bytes
	} tx_state_t;

endpackage

`default_nettype wire

// File: verilog/crc_comb.sv
// crc_comb
// combinational crc-32 step over one byte, chained from a given register value
// also finishes the previous register (reorder + invert) and compares it

`timescale 1ns/1ps
`default_nettype none

`include "crc_defines.svh"

module crc_comb
(
	input  crc_pkg::data_t data_in,  // byte to fold in
	input  crc_pkg::crc_t  crc_prev, // raw register before this byte
	input  crc_pkg::crc_t  crc_in,   // expected crc
	output crc_pkg::crc_t  crc_next, // raw register after this byte
	output crc_pkg::crc_t  crc_out,  // finished crc of crc_prev
	output logic           crc_ok    // crc_in matches crc_out
);

	// --------------------------------------------------
	// bit reordering
	// --------------------------------------------------

	// input byte, so the division below can always run msb first
	function automatic crc_pkg::data_t order_data(input crc_pkg::data_t d);
		crc_pkg::data_t r;
		r = d;
		if (`CRC_BIT_ORDER == 1)
		begin
			for (int i = 0; i < `CRC_DATA_W; i++)
				r[i] = d[`CRC_DATA_W-1-i]; // full mirror
		end
		else if (`CRC_BIT_ORDER == 2)
		begin
			for (int k = 0; k < `CRC_DATA_W/8; k++)
				r[8*k +: 8] = d[`CRC_DATA_W-8-8*k +: 8]; // byte swap
		end
		else if (`CRC_BIT_ORDER == 3)
		begin
			for (int k = 0; k < `CRC_DATA_W/8; k++)
				for (int j = 0; j < 8; j++)
					r[8*k+j] = d[8*k+7-j]; // mirror inside each byte
		end
		return r;
	endfunction

	// same reordering on the register side
	function automatic crc_pkg::crc_t order_crc(input crc_pkg::crc_t c);
		crc_pkg::crc_t r;
		r = c;
		if (`CRC_BIT_ORDER == 1)
		begin
			for (int i = 0; i < `CRC_W; i++)
				r[i] = c[`CRC_W-1-i];
		end
		else if (`CRC_BIT_ORDER == 2)
		begin
			for (int k = 0; k < `CRC_W/8; k++)
				r[8*k +: 8] = c[`CRC_W-8-8*k +: 8];
		end
		else if (`CRC_BIT_ORDER == 3)
		begin
			for (int k = 0; k < `CRC_W/8; k++)
				for (int j = 0; j < 8; j++)
					r[8*k+j] = c[8*k+7-j];
		end
		return r;
	endfunction

	// --------------------------------------------------
	// unrolled division, one bit per iteration
	// --------------------------------------------------
	always_comb
	begin : div_step
		crc_pkg::crc_t  c;
		crc_pkg::data_t d;
		logic           fb;
		c = crc_prev;
		d = order_data(data_in);
		for (int i = 0; i < `CRC_DATA_W; i++)
		begin
			fb = c[`CRC_W-1] ^ d[`CRC_DATA_W-1]; // feedback bit
			c  = c << 1;
			if (fb)
				c = c ^ `CRC_POLY;
			d  = d << 1;
		end
		crc_next = c;
	end

	// finish the incoming register value, then check
	assign crc_out = order_crc(crc_prev) ^ `CRC_XOR_OUT;
	assign crc_ok  = (crc_in == crc_out);

endmodule

`default_nettype wire

// File: verilog/crc_engine.sv
// crc_engine
// running crc register, seeded at start of frame, stepped per valid byte
// finished crc and compare always describe the bytes taken so far

`timescale 1ns/1ps
`default_nettype none

`include "crc_defines.svh"

module crc_engine
(
	input  logic           clk,
	input  logic           rst,
	input  crc_pkg::data_t data,
	input  logic           valid,
	input  logic           sof,     // first byte of a frame
	input  crc_pkg::crc_t  crc_in,  // value to compare against
	output crc_pkg::crc_t  crc_out, // finished crc of register
	output logic           crc_ok
);

	crc_pkg::crc_t crc_reg;   // raw running register
	crc_pkg::crc_t step_next; // register after data, chained
	crc_pkg::crc_t seed_next; // register after data, from preset

	// chained step, finish and compare all read the live register
	crc_comb step_inst
	(
		.data_in  (data),
		.crc_prev (crc_reg),
		.crc_in   (crc_in),
		.crc_next (step_next),
		.crc_out  (crc_out),
		.crc_ok   (crc_ok)
	);

	// first byte of a frame, so a new frame can start while the
	// old result is still being read
	crc_comb seed_inst
	(
		.data_in  (data),
		.crc_prev (`CRC_PRESET),
		.crc_in   (crc_in),
		.crc_next (seed_next),
		.crc_out  (),
		.crc_ok   ()
	);

	always_ff @(posedge clk)
	begin
		if (rst)
			crc_reg <= `CRC_PRESET;
		else if (valid)
			crc_reg <= sof ? seed_next : step_next; // restart on sof
	end

endmodule

`default_nettype wire

// File: verilog/crc_tx_append.sv
// crc_tx_append
// transmit framer, payload goes out one cycle late, then four crc bytes
// low byte first, source held off with tx_busy while the tail runs

`timescale 1ns/1ps
`default_nettype none

`include "crc_defines.svh"

module crc_tx_append
(
	input  logic           clk,
	input  logic           rst,
	input  crc_pkg::data_t tx_data,
	input  logic           tx_valid,
	input  logic           tx_sof,
	input  logic           tx_eof,
	output crc_pkg::data_t out_data,
	output logic           out_valid,
	output logic           out_tail,  // crc byte on out_data
	output logic           tx_busy    // no new bytes while high
);

	crc_pkg::tx_state_t state;
	logic [1:0]         tail_idx;     // crc byte being sent
	crc_pkg::crc_t      crc_val;      // finished crc of the frame
	logic               in_tail;
	logic               tail_last;

	// crc_in loops back to the output, compare result not needed here
	crc_engine engine_inst
	(
		.clk     (clk),
		.rst     (rst),
		.data    (tx_data),
		.valid   (tx_valid),
		.sof     (tx_sof),
		.crc_in  (crc_val),
		.crc_out (crc_val),
		.crc_ok  ()
	);

	assign in_tail   = (state == crc_pkg::TX_TAIL);
	assign tail_last = (tail_idx == 2'(`CRC_TAIL_BYTES - 1));
	assign tx_busy   = in_tail;

	// --------------------------------------------------
	// framing fsm
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state    <= crc_pkg::TX_IDLE;
			tail_idx <= '0;
		end
		else
		begin
			case (state)
				crc_pkg::TX_IDLE,
				crc_pkg::TX_DATA:
				begin
					if (tx_valid && tx_eof)
						state <= crc_pkg::TX_TAIL; // one-byte frame too
					else if (tx_valid && tx_sof)
						state <= crc_pkg::TX_DATA;
				end
				crc_pkg::TX_TAIL:
				begin
					tail_idx <= tail_idx + 2'd1; // wraps back to 0
					if (tail_last)
						state <= crc_pkg::TX_IDLE;
				end
				default: state <= crc_pkg::TX_IDLE;
			endcase
		end
	end

	// --------------------------------------------------
	// output register
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			out_valid <= 1'b0;
			out_tail  <= 1'b0;
		end
		else
		begin
			out_valid <= tx_valid | in_tail;
			out_tail  <= in_tail;
		end
	end

	// payload byte, or crc byte picked by tail index
	always_ff @(posedge clk)
	begin
		if (in_tail)
			out_data <= crc_val[8*tail_idx +: `CRC_DATA_W];
		else
			out_data <= tx_data;
	end

endmodule

`default_nettype wire

// File: verilog/crc_rx_check.sv
// crc_rx_check
// receive checker, crc of the payload against rx_crc from the eof byte
// pass/fail one cycle after eof, saturating error count

`timescale 1ns/1ps
`default_nettype none

module crc_rx_check
(
	input  logic           clk,
	input  logic           rst,
	input  crc_pkg::data_t rx_data,
	input  logic           rx_valid,
	input  logic           rx_sof,
	input  logic           rx_eof,
	input  crc_pkg::crc_t  rx_crc,       // sampled with the eof byte
	output logic           rx_done,      // one-cycle result strobe
	output logic           rx_crc_ok,
	output logic [15:0]    rx_err_count
);

	crc_pkg::crc_t crc_hold; // expected crc of the frame
	logic          eng_ok;
	logic          ok_hold;  // last frame result
	logic          eof_hit;

	// finished crc stays inside, only the compare comes out
	crc_engine engine_inst
	(
		.clk     (clk),
		.rst     (rst),
		.data    (rx_data),
		.valid   (rx_valid),
		.sof     (rx_sof),
		.crc_in  (crc_hold),
		.crc_out (),
		.crc_ok  (eng_ok)
	);

	assign eof_hit = rx_valid & rx_eof;

	always_ff @(posedge clk)
	begin
		if (eof_hit)
			crc_hold <= rx_crc;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rx_done      <= 1'b0;
			ok_hold      <= 1'b0;
			rx_err_count <= '0;
		end
		else
		begin
			rx_done <= eof_hit;
			if (rx_done)
			begin
				ok_hold <= eng_ok;   // engine still holds the whole frame here
				if (!eng_ok && rx_err_count != 16'hFFFF)
					rx_err_count <= rx_err_count + 16'd1;
			end
		end
	end

	// live result on the done cycle, held after
	assign rx_crc_ok = rx_done ? eng_ok : ok_hold;

endmodule

`default_nettype wire

// File: verilog/crc_link.sv
// crc_link
// crc-32 link top, transmit framer with crc append and receive checker

`timescale 1ns/1ps
`default_nettype none

module crc_link
(
	input  logic           clk,
	input  logic           rst,

	// --------------------------------------------------
	// transmit side
	// --------------------------------------------------
	input  crc_pkg::data_t tx_data,
	input  logic           tx_valid,
	input  logic           tx_sof,
	input  logic           tx_eof,
	output crc_pkg::data_t out_data,
	output logic           out_valid,
	output logic           out_tail,
	output logic           tx_busy,

	// --------------------------------------------------
	// receive side
	// --------------------------------------------------
	input  crc_pkg::data_t rx_data,
	input  logic           rx_valid,
	input  logic           rx_sof,
	input  logic           rx_eof,
	input  crc_pkg::crc_t  rx_crc,
	output logic           rx_done,
	output logic           rx_crc_ok,
	output logic [15:0]    rx_err_count
);

	crc_tx_append tx_inst
	(
		.clk       (clk),
		.rst       (rst),
		.tx_data   (tx_data),
		.tx_valid  (tx_valid),
		.tx_sof    (tx_sof),
		.tx_eof    (tx_eof),
		.out_data  (out_data),
		.out_valid (out_valid),
		.out_tail  (out_tail),
		.tx_busy   (tx_busy)
	);

	crc_rx_check rx_inst
	(
		.clk          (clk),
		.rst          (rst),
		.rx_data      (rx_data),
		.rx_valid     (rx_valid),
		.rx_sof       (rx_sof),
		.rx_eof       (rx_eof),
		.rx_crc       (rx_crc),
		.rx_done      (rx_done),
		.rx_crc_ok    (rx_crc_ok),
		.rx_err_count (rx_err_count)
	);

endmodule

`default_nettype wire

// File: bench/crc_link_properties.sv
// crc_link_properties
// bound checks on transmit busy behavior and receive result strobes

`timescale 1ns/1ps
`default_nettype none

module crc_link_properties
(
	input logic        clk,
	input logic        rst,
	input logic        valid, // tx_valid
	input logic        busy,  // tx_busy
	input logic        done,  // rx_done
	input logic [15:0] count  // rx_err_count
);

	// source holds off during the tail
	a_no_valid_busy: assert property (@(posedge clk) disable iff (rst) busy |-> !valid)
		else $error("tx_valid raised while tx_busy is high");

	// tail window is four cycles long
	a_busy_len: assert property (@(posedge clk) disable iff (rst)
		$fell(busy) |-> $past(busy, 1) && $past(busy, 2) && $past(busy, 3)
			&& $past(busy, 4) && !$past(busy, 5))
		else $error("tx_busy high for other than four cycles");

	a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else $error("rx_done high for more than one cycle");

	// saturating counter, never goes down
	a_count_up: assert property (@(posedge clk) disable iff (rst) count >= $past(count))
		else $error("rx_err_count decreased");

endmodule

// --------------------------------------------------
// attach to the transmit and receive blocks
// --------------------------------------------------
bind crc_tx_append crc_link_properties tx_props
(
	.clk   (clk),
	.rst   (rst),
	.valid (tx_valid),
	.busy  (tx_busy),
	.done  (1'b0),
	.count (16'd0)
);

bind crc_rx_check crc_link_properties rx_props
(
	.clk   (clk),
	.rst   (rst),
	.valid (1'b0),
	.busy  (1'b0),
	.done  (rx_done),
	.count (rx_err_count)
);

`default_nettype wire

// File: bench/crc_link_tb.sv
// crc_link_tb
// directed tests for the crc-32 link, transmit append and receive check
// reference crc is a bitwise reflected model, lsb first

`timescale 1ns/1ps
`default_nettype none

`include "crc_defines.svh"

module crc_link_tb;

	localparam int TIMEOUT = 2000; // cycles per wait

	logic           clk;
	logic           rst;
	crc_pkg::data_t tx_data;
	logic           tx_valid;
	logic           tx_sof;
	logic           tx_eof;
	crc_pkg::data_t out_data;
	logic           out_valid;
	logic           out_tail;
	logic           tx_busy;
	crc_pkg::data_t rx_data;
	logic           rx_valid;
	logic           rx_sof;
	logic           rx_eof;
	crc_pkg::crc_t  rx_crc;
	logic           rx_done;
	logic           rx_crc_ok;
	logic [15:0]    rx_err_count;

	int             checks;
	int             errors;
	int             checks0;  // counts at test start
	int             errors0;
	crc_pkg::data_t tx_got[$]; // collected output bytes
	logic           tx_tail[$];
	logic           done_q[$]; // rx_crc_ok per rx_done

	crc_link crc_link_inst (.*);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	// output monitors, sampled mid cycle
	always @(negedge clk)
	begin
		if (!rst && out_valid)
		begin
			tx_got.push_back(out_data);
			tx_tail.push_back(out_tail);
		end
		if (!rst && rx_done)
			done_q.push_back(rx_crc_ok);
	end

	// --------------------------------------------------
	// reference model and compare tasks
	// --------------------------------------------------
	function automatic crc_pkg::crc_t ref_crc(input crc_pkg::data_t q[$]);
		crc_pkg::crc_t c;
		crc_pkg::crc_t poly;
		crc_pkg::crc_t poly_r; // mirrored polynomial
		poly = `CRC_POLY;
		for (int i = 0; i < `CRC_W; i++)
			poly_r[i] = poly[`CRC_W-1-i];
		c = `CRC_PRESET;
		foreach (q[i])
		begin
			c = c ^ crc_pkg::crc_t'(q[i]);
			for (int b = 0; b < `CRC_DATA_W; b++)
				c = c[0] ? ((c >> 1) ^ poly_r) : (c >> 1); // lsb first
		end
		return c ^ `CRC_XOR_OUT;
	endfunction

	task automatic check_byte(input string name, input crc_pkg::data_t got,
		input crc_pkg::data_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0t %s got %02h expected %02h", $time, name, got, exp);
		end
	endtask

	task automatic check_crc(input string name, input crc_pkg::crc_t got,
		input crc_pkg::crc_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0t %s got %08h expected %08h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic start_test();
		checks0 = checks;
		errors0 = errors;
	endtask

	task automatic end_test(input string name);
		$display("%s: %0d checks, %0d errors", name, checks - checks0, errors - errors0);
	endtask

	// --------------------------------------------------
	// stimulus helpers
	// --------------------------------------------------
	task automatic random_frame(output crc_pkg::data_t q[$], input int len);
		q.delete();
		repeat (len)
			q.push_back(crc_pkg::data_t'($urandom));
	endtask

	task automatic wait_queue(input int n, input bit rx_side);
		int t;
		t = 0;
		while ((rx_side ? done_q.size() : tx_got.size()) < n && t < TIMEOUT)
		begin
			@(posedge clk);
			#1;
			t++;
		end
		if ((rx_side ? done_q.size() : tx_got.size()) < n)
		begin
			$display("timeout: %0s output never reached %0d entries",
				rx_side ? "receive" : "transmit", n);
			$display("*** TEST FAILED ***");
			$finish;
		end
	endtask

	// send a frame, check busy window, then payload and tail
	task automatic run_tx_frame(input crc_pkg::data_t q[$]);
		crc_pkg::crc_t c;
		int            n;
		c = ref_crc(q);
		n = q.size();
		tx_got.delete();
		tx_tail.delete();
		for (int i = 0; i < n; i++)
		begin
			@(posedge clk);
			#1;
			tx_data  = q[i];
			tx_valid = 1'b1;
			tx_sof   = (i == 0);
			tx_eof   = (i == n - 1);
		end
		@(posedge clk);
		#1;
		tx_valid = 1'b0;
		tx_sof   = 1'b0;
		tx_eof   = 1'b0;
		for (int k = 0; k < `CRC_TAIL_BYTES; k++)
		begin
			check_flag("tx_busy", tx_busy, 1'b1);
			@(posedge clk);
			#1;
		end
		check_flag("tx_busy", tx_busy, 1'b0); // window over
		wait_queue(n + `CRC_TAIL_BYTES, 1'b0);
		check_flag("out_valid", out_valid, 1'b0); // nothing after the last tail byte
		for (int i = 0; i < n; i++)
		begin
			check_byte("out_data", tx_got[i], q[i]);
			check_flag("out_tail", tx_tail[i], 1'b0);
		end
		for (int k = 0; k < `CRC_TAIL_BYTES; k++)
		begin
			check_byte("out_data tail", tx_got[n+k], c[8*k +: 8]); // low byte first
			check_flag("out_tail", tx_tail[n+k], 1'b1);
		end
	endtask

	task automatic send_rx(input crc_pkg::data_t q[$], input crc_pkg::crc_t crc);
		for (int i = 0; i < q.size(); i++)
		begin
			@(posedge clk);
			#1;
			rx_data  = q[i];
			rx_valid = 1'b1;
			rx_sof   = (i == 0);
			rx_eof   = (i == q.size() - 1);
			rx_crc   = (i == q.size() - 1) ? crc : '0;
		end
	endtask

	task automatic rx_idle();
		@(posedge clk);
		#1;
		rx_valid = 1'b0;
		rx_sof   = 1'b0;
		rx_eof   = 1'b0;
	endtask

	// one frame, result one cycle after eof, count one cycle later
	task automatic check_rx_frame(input crc_pkg::data_t q[$], input crc_pkg::crc_t crc);
		logic        exp_ok;
		logic [15:0] cnt0;
		exp_ok = (ref_crc(q) == crc);
		cnt0   = rx_err_count;
		send_rx(q, crc);
		rx_idle();
		check_flag("rx_done", rx_done, 1'b1);
		check_flag("rx_crc_ok", rx_crc_ok, exp_ok);
		@(posedge clk);
		#1;
		check_flag("rx_done", rx_done, 1'b0);
		check_flag("rx_crc_ok", rx_crc_ok, exp_ok); // held
		check_count("rx_err_count", rx_err_count, exp_ok ? cnt0 : cnt0 + 16'd1);
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------
	task automatic test_reset_state();
		start_test();
		check_flag("out_valid", out_valid, 1'b0);
		check_flag("out_tail", out_tail, 1'b0);
		check_flag("tx_busy", tx_busy, 1'b0);
		check_flag("rx_done", rx_done, 1'b0);
		check_flag("rx_crc_ok", rx_crc_ok, 1'b0);
		check_count("rx_err_count", rx_err_count, 16'd0);
		end_test("reset state");
	endtask

	task automatic test_check_value();
		string          msg;
		crc_pkg::data_t q[$];
		msg = "123456789";
		start_test();
		for (int i = 0; i < msg.len(); i++)
			q.push_back(msg[i]);
		check_crc("model check value", ref_crc(q), 32'hCBF43926); // tail 26 39 f4 cb
		run_tx_frame(q);
		end_test("tx check value");
	endtask

	task automatic test_tx_random();
		crc_pkg::data_t q[$];
		start_test();
		repeat (20)
		begin
			random_frame(q, $urandom_range(1, 64));
			run_tx_frame(q);
			repeat ($urandom_range(1, 5)) @(posedge clk); // idle gap
		end
		end_test("tx random frames");
	endtask

	task automatic test_rx_good();
		crc_pkg::data_t q[$];
		start_test();
		repeat (8)
		begin
			random_frame(q, $urandom_range(1, 64));
			check_rx_frame(q, ref_crc(q));
		end
		end_test("rx good frames");
	endtask

	task automatic test_rx_corrupt();
		crc_pkg::data_t q[$];
		crc_pkg::crc_t  c;
		int             idx;
		start_test();
		repeat (8)
		begin
			random_frame(q, $urandom_range(1, 64));
			c = ref_crc(q);
			if ($urandom_range(0, 1) == 0)
			begin
				idx    = $urandom_range(0, q.size() - 1);
				q[idx] = q[idx] ^ (crc_pkg::data_t'(1) << $urandom_range(0, 7)); // payload bit
			end
			else
				c = c ^ (crc_pkg::crc_t'(1) << $urandom_range(0, 31)); // crc bit
			check_rx_frame(q, c);
		end
		end_test("rx corrupted frames");
	endtask

	task automatic test_rx_back_to_back();
		crc_pkg::data_t q[$];
		crc_pkg::crc_t  c;
		logic           exp_q[$];
		logic [15:0]    cnt0;
		start_test();
		done_q.delete();
		cnt0 = rx_err_count;
		for (int f = 0; f < 3; f++)
		begin
			random_frame(q, $urandom_range(2, 16));
			c = ref_crc(q);
			if (f == 1)
				c = c ^ (crc_pkg::crc_t'(1) << $urandom_range(0, 31)); // middle frame bad
			exp_q.push_back(ref_crc(q) == c);
			send_rx(q, c); // sof right after previous eof
		end
		rx_idle();
		wait_queue(3, 1'b1);
		foreach (exp_q[i])
			check_flag("rx_crc_ok", done_q[i], exp_q[i]);
		check_count("rx_err_count", rx_err_count, cnt0 + 16'd1);
		random_frame(q, 1); // sof and eof together
		check_rx_frame(q, ref_crc(q));
		end_test("rx back to back");
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial
	begin
		void'($urandom(74523));
		checks   = 0;
		errors   = 0;
		rst      = 1'b1;
		tx_data  = '0;
		tx_valid = 1'b0;
		tx_sof   = 1'b0;
		tx_eof   = 1'b0;
		rx_data  = '0;
		rx_valid = 1'b0;
		rx_sof   = 1'b0;
		rx_eof   = 1'b0;
		rx_crc   = '0;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;

		test_reset_state();
		test_check_value();
		test_tx_random();
		test_rx_good();
		test_rx_corrupt();
		test_rx_back_to_back();

		$display("totals: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
verilog/crc_pkg.sv
verilog/crc_comb.sv
verilog/crc_engine.sv
verilog/crc_tx_append.sv
verilog/crc_rx_check.sv
verilog/crc_link.sv
bench/crc_link_properties.sv
bench/crc_link_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the crc link testbench with verilator
# fails on a build error, a simulator error or a failed check

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -j 0 --top-module crc_link_tb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vcrc_link_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
	exit 1
fi
exit 0
